// File: source/noc_mlp_pkg.sv
//##########################################################################
// node ids, flit layout and opcodes shared by the whole design
// flit is 37 bits, dest on top and lane 0 in the lowest byte of data
//##########################################################################

package noc_mlp_pkg;

    localparam int lanes   = 4;      // vector elements per flit
    localparam int lane_w  = 8;      // signed int8
    localparam int dest_w  = 2;
    localparam int row_w   = 2;
    localparam int n_nodes = 1 << dest_w;

    // node ids on the switch
    localparam logic [dest_w-1:0] node_inject = 2'd0;
    localparam logic [dest_w-1:0] node_tile0  = 2'd1;
    localparam logic [dest_w-1:0] node_tile1  = 2'd2;
    localparam logic [dest_w-1:0] node_eject  = 2'd3;

    typedef enum logic {
        op_weight = 1'b0,   // data holds one weight row
        op_vector = 1'b1
    } flit_op_e;

    typedef struct packed {
        logic [dest_w-1:0]       dest;
        flit_op_e                op;
        logic [row_w-1:0]        row;   // weight row, 0 on vectors
        logic [lanes*lane_w-1:0] data;
    } flit_t;

    localparam int in_word_w  = $bits(flit_t);   // an input word is a whole flit
    localparam int out_word_w = lanes * lane_w;  // results carry data only

endpackage

// File: source/flit_if.sv
//##########################################################################
// valid/ready flit link, transfer on a clock edge with both high
// sender holds valid and flit stable until the transfer
//##########################################################################

interface flit_if;
    import noc_mlp_pkg::*;

    logic  valid;
    logic  ready;
    flit_t flit;

    modport sender (
        output valid,
        output flit,
        input  ready
    );

    modport receiver (
        input  valid,
        input  flit,
        output ready
    );

endinterface

// File: source/sync_fifo.sv
//##########################################################################
// show-ahead synchronous FIFO, write visible at the head one cycle later
// writes when full and reads when empty are dropped
//##########################################################################

module sync_fifo #(
    parameter int width = 32,
    parameter int depth = 8
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [width-1:0] wdata,
    input  logic             wen,
    output logic             full,
    output logic [width-1:0] rdata,
    input  logic             ren,
    output logic             empty
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam int cw = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [aw-1:0]    wr_ptr;
    logic [aw-1:0]    rd_ptr;
    logic [cw-1:0]    count;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [aw-1:0] bump(input logic [aw-1:0] ptr);
        return (ptr == aw'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full  = (count == cw'(depth));
    assign empty = (count == '0);
    assign do_wr = wen & ~full;
    assign do_rd = ren & ~empty;
    assign rdata = mem[rd_ptr];   // head, no read latency

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= bump(wr_ptr);
            if (do_rd) rd_ptr <= bump(rd_ptr);
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wdata;
    end

endmodule

// File: source/noc_switch.sv
//##########################################################################
// crossbar over all nodes, routed by flit dest, one register per output
// round-robin per output, a full output register stalls its sources
//##########################################################################

module noc_switch (
    input logic      clk,
    input logic      arst_n,
    flit_if.receiver in  [noc_mlp_pkg::n_nodes],
    flit_if.sender   out [noc_mlp_pkg::n_nodes]
);
    import noc_mlp_pkg::*;

    logic  [n_nodes-1:0]              in_vld;
    logic  [n_nodes-1:0]              in_rdy;
    flit_t                            in_flit [n_nodes];
    logic  [n_nodes-1:0]              out_vld;
    logic  [n_nodes-1:0]              out_rdy;
    flit_t                            out_q [n_nodes];
    logic  [n_nodes-1:0]              can_load;
    logic  [n_nodes-1:0][n_nodes-1:0] gnt;   // [output][input]
    logic  [n_nodes-1:0][dest_w-1:0]  win;
    logic  [n_nodes-1:0][dest_w-1:0]  rr;    // last input served per output

    for (genvar n = 0; n < n_nodes; n++) begin : g_link
        assign in_vld[n]     = in[n].valid;
        assign in_flit[n]    = in[n].flit;
        assign in[n].ready   = in_rdy[n];
        assign out[n].valid  = out_vld[n];
        assign out[n].flit   = out_q[n];
        assign out_rdy[n]    = out[n].ready;
    end

    // empty or draining this cycle
    assign can_load = ~out_vld | out_rdy;

    // search starts one past the last winner
    always_comb begin
        logic [dest_w-1:0] idx;
        logic              hit;
        gnt = '0;
        win = '0;
        for (int o = 0; o < n_nodes; o++) begin
            hit = 1'b0;
            for (int k = 1; k <= n_nodes; k++) begin
                idx = rr[o] + dest_w'(k);   // wraps, last winner comes last
                if (!hit && in_vld[idx] && in_flit[idx].dest == dest_w'(o)) begin
                    hit         = 1'b1;
                    win[o]      = idx;
                    gnt[o][idx] = can_load[o];
                end
            end
        end
    end

    // an input targets one output only
    always_comb begin
        in_rdy = '0;
        for (int o = 0; o < n_nodes; o++) begin
            in_rdy = in_rdy | gnt[o];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_vld <= '0;
            rr      <= '0;
        end else begin
            for (int o = 0; o < n_nodes; o++) begin
                if (can_load[o]) out_vld[o] <= |gnt[o];
                if (|gnt[o]) rr[o] <= win[o];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < n_nodes; o++) begin
            if (|gnt[o]) out_q[o] <= in_flit[win[o]];
        end
    end

endmodule

// File: source/mvm_tile.sv
//##########################################################################
// 4x4 int8 matrix times vector, results shifted right by shift and clipped
// weight flits always accepted, vectors need two cycles to reach tx
//##########################################################################

module mvm_tile #(
    parameter int                             shift     = 4,
    parameter logic [noc_mlp_pkg::dest_w-1:0] next_node = noc_mlp_pkg::node_eject
) (
    input logic      clk,
    input logic      arst_n,
    flit_if.receiver rx,
    flit_if.sender   tx
);
    import noc_mlp_pkg::*;

    localparam int prod_w = 2 * lane_w;
    localparam int acc_w  = prod_w + $clog2(lanes);
    localparam logic signed [acc_w-1:0] sat_hi = acc_w'((1 << (lane_w - 1)) - 1);
    localparam logic signed [acc_w-1:0] sat_lo = acc_w'(-(1 << (lane_w - 1)));

    logic signed [lane_w-1:0] w [lanes][lanes];      // [row][col]
    logic signed [lane_w-1:0] x [lanes];
    logic signed [prod_w-1:0] prod [lanes][lanes];
    logic [lanes*lane_w-1:0]  res;
    logic [lanes*lane_w-1:0]  res_q;
    logic                     s1_vld;
    logic                     s2_vld;
    logic                     adv1;
    logic                     adv2;
    logic                     is_vec;
    logic                     vec_take;
    logic                     wgt_take;

    always_comb begin
        for (int c = 0; c < lanes; c++) begin
            x[c] = rx.flit.data[c*lane_w +: lane_w];
        end
    end

    assign is_vec   = (rx.flit.op == op_vector);
    assign adv2     = ~s2_vld | tx.ready;
    assign adv1     = ~s1_vld | adv2;
    assign rx.ready = ~is_vec | adv1;     // stalls only vectors
    assign vec_take = rx.valid & is_vec & adv1;
    assign wgt_take = rx.valid & ~is_vec;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            w <= '{default: '0};
        end else if (wgt_take) begin
            for (int c = 0; c < lanes; c++) begin
                w[rx.flit.row][c] <= x[c];
            end
        end
    end

    // stage one, products
    always_ff @(posedge clk) begin
        if (vec_take) begin
            for (int r = 0; r < lanes; r++) begin
                for (int c = 0; c < lanes; c++) begin
                    prod[r][c] <= w[r][c] * x[c];
                end
            end
        end
    end

    // row sums, floor shift, clip to int8
    always_comb begin
        logic signed [acc_w-1:0] acc;
        logic signed [acc_w-1:0] sh;
        res = '0;
        for (int r = 0; r < lanes; r++) begin
            acc = '0;
            for (int c = 0; c < lanes; c++) begin
                acc = acc + prod[r][c];
            end
            sh = acc >>> shift;
            if (sh > sat_hi) begin
                res[r*lane_w +: lane_w] = sat_hi[lane_w-1:0];
            end else if (sh < sat_lo) begin
                res[r*lane_w +: lane_w] = sat_lo[lane_w-1:0];
            end else begin
                res[r*lane_w +: lane_w] = sh[lane_w-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (adv2 && s1_vld) res_q <= res;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
        end else begin
            if (adv1) s1_vld <= vec_take;
            if (adv2) s2_vld <= s1_vld;
        end
    end

    assign tx.valid = s2_vld;
    assign tx.flit  = '{dest: next_node, op: op_vector, row: '0, data: res_q};

endmodule

// File: source/noc_mlp_top.sv
//##########################################################################
// input FIFO -> switch -> tile0 -> tile1 -> output FIFO, routed per flit
// ififo words are whole flits, ofifo words carry the result data only
//##########################################################################

module noc_mlp_top #(
    parameter int fifo_depth = 8,
    parameter int shift      = 4
) (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [noc_mlp_pkg::in_word_w-1:0]  ififo_wdata,
    input  logic                               ififo_wen,
    output logic                               ififo_rdy,
    output logic [noc_mlp_pkg::out_word_w-1:0] ofifo_rdata,
    input  logic                               ofifo_ren,
    output logic                               ofifo_rdy
);
    import noc_mlp_pkg::*;

    logic [in_word_w-1:0] inj_rdata;
    logic                 inj_full;
    logic                 inj_empty;
    logic                 inj_pop;
    logic                 ej_full;
    logic                 ej_empty;

    flit_if to_sw   [n_nodes] ();
    flit_if from_sw [n_nodes] ();

    // input FIFO head drives the inject node
    assign to_sw[node_inject].valid   = ~inj_empty;
    assign to_sw[node_inject].flit    = inj_rdata;
    assign inj_pop                    = to_sw[node_inject].valid & to_sw[node_inject].ready;
    assign from_sw[node_inject].ready = 1'b1;   // stray flits to node 0 are dropped
    assign ififo_rdy                  = ~inj_full;

    // eject node only receives
    assign to_sw[node_eject].valid    = 1'b0;
    assign to_sw[node_eject].flit     = '0;
    assign from_sw[node_eject].ready  = ~ej_full;
    assign ofifo_rdy                  = ~ej_empty;

    sync_fifo #(.width(in_word_w), .depth(fifo_depth)) u_inject_fifo (
        .clk   (clk),
        .arst_n(arst_n),
        .wdata (ififo_wdata),
        .wen   (ififo_wen),
        .full  (inj_full),
        .rdata (inj_rdata),
        .ren   (inj_pop),
        .empty (inj_empty)
    );

    noc_switch u_switch (
        .clk   (clk),
        .arst_n(arst_n),
        .in    (to_sw),
        .out   (from_sw)
    );

    mvm_tile #(.shift(shift), .next_node(node_tile1)) u_tile0 (
        .clk   (clk),
        .arst_n(arst_n),
        .rx    (from_sw[node_tile0]),
        .tx    (to_sw[node_tile0])
    );

    mvm_tile #(.shift(shift), .next_node(node_eject)) u_tile1 (
        .clk   (clk),
        .arst_n(arst_n),
        .rx    (from_sw[node_tile1]),
        .tx    (to_sw[node_tile1])
    );

    sync_fifo #(.width(out_word_w), .depth(fifo_depth)) u_eject_fifo (
        .clk   (clk),
        .arst_n(arst_n),
        .wdata (from_sw[node_eject].flit.data),
        .wen   (from_sw[node_eject].valid),
        .full  (ej_full),
        .rdata (ofifo_rdata),
        .ren   (ofifo_ren),
        .empty (ej_empty)
    );

endmodule

// File: tests/noc_mlp_assertions.sv
//##########################################################################
// switch output register checks bound into noc_switch
//##########################################################################

module noc_mlp_assertions (
    input logic                              clk,
    input logic                              arst_n,
    input logic [noc_mlp_pkg::n_nodes-1:0]   out_vld,
    input logic [noc_mlp_pkg::n_nodes-1:0]   out_rdy,
    input noc_mlp_pkg::flit_t                out_q [noc_mlp_pkg::n_nodes]
);
    timeunit 1ns;
    timeprecision 100ps;
    import noc_mlp_pkg::*;

    int fail_count = 0;

    for (genvar o = 0; o < n_nodes; o++) begin : g_out
        // flit held until the receiver takes it
        hold_until_ready: assert property (
            @(posedge clk) disable iff (!arst_n)
            out_vld[o] && !out_rdy[o] |=> out_vld[o] && $stable(out_q[o])
        ) else begin
            fail_count++;
            $error("switch output %0d dropped or changed a flit before ready", o);
        end

        dest_matches: assert property (
            @(posedge clk) disable iff (!arst_n)
            out_vld[o] |-> out_q[o].dest == dest_w'(o)
        ) else begin
            fail_count++;
            $error("switch output %0d carries a flit for another node", o);
        end
    end

    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> out_vld == '0)
        else begin
            fail_count++;
            $error("switch output valid while arst_n is low");
        end

endmodule

// File: tests/noc_mlp_tb.sv
//##########################################################################
// covers reset, passthrough, one and two layers and back-pressure
// fifo_depth is 4 so twenty held vectors fill the input FIFO
//##########################################################################

module noc_mlp_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import noc_mlp_pkg::*;

    localparam int fifo_depth  = 4;
    localparam int shift       = 4;
    localparam int n_table     = 5;
    localparam int n_tests     = n_table + 1;   // table plus the reset check
    localparam int cycle_limit = 16 + 300 * n_tests;

    typedef enum logic [1:0] {m_pass, m_one, m_two, m_bp} mode_e;

    // name, mode, weight set (0 small, 1 saturating), vector count
    string names  [n_table] = '{"passthrough", "one_layer", "two_layer_sat", "two_layer",
                                "backpressure"};
    mode_e modes  [n_table] = '{m_pass, m_one, m_two, m_two, m_bp};
    int    wsels  [n_table] = '{0, 0, 1, 0, 0};
    int    counts [n_table] = '{6, 8, 8, 6, 20};

    logic                  clk;
    logic                  arst_n;
    logic [in_word_w-1:0]  ififo_wdata;
    logic                  ififo_wen;
    logic                  ififo_rdy;
    logic [out_word_w-1:0] ofifo_rdata;
    logic                  ofifo_ren;
    logic                  ofifo_rdy;

    logic [31:0]           lfsr;
    int                    wgt [2][lanes][lanes];   // weights as loaded into both tiles
    logic [in_word_w-1:0]  words [$];
    logic [out_word_w-1:0] exp_q [$];
    int                    cycles;
    int                    errors;
    int                    failed_tests;
    int                    assert_fails;

    noc_mlp_top #(.fifo_depth(fifo_depth), .shift(shift)) i_noc_mlp_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .ififo_wdata(ififo_wdata),
        .ififo_wen  (ififo_wen),
        .ififo_rdy  (ififo_rdy),
        .ofifo_rdata(ofifo_rdata),
        .ofifo_ren  (ofifo_ren),
        .ofifo_rdy  (ofifo_rdy)
    );

    bind noc_switch noc_mlp_assertions u_switch_chk (
        .clk    (clk),
        .arst_n (arst_n),
        .out_vld(out_vld),
        .out_rdy(out_rdy),
        .out_q  (out_q)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT stopped producing results", cycles);
        $display("sim failed");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // clip(floor(W x / 2**shift)) per row
    function automatic logic [31:0] tile_model(input int t, input logic [31:0] x);
        logic [31:0] y;
        int          acc;
        y = '0;
        for (int r = 0; r < lanes; r++) begin
            acc = 0;
            for (int c = 0; c < lanes; c++) begin
                acc += wgt[t][r][c] * int'($signed(x[c*lane_w +: lane_w]));
            end
            acc = acc >>> shift;
            if (acc > 127) acc = 127;
            if (acc < -128) acc = -128;
            y[r*lane_w +: lane_w] = 8'(acc);
        end
        return y;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic queue_weights(input int t, input int wsel);
        logic [31:0] row_data;
        logic [1:0]  dest;
        dest = (t == 0) ? node_tile0 : node_tile1;
        for (int r = 0; r < lanes; r++) begin
            row_data = '0;
            for (int c = 0; c < lanes; c++) begin
                if (wsel == 1) wgt[t][r][c] = take_bits(1) ? 127 : -128;
                else wgt[t][r][c] = int'($signed(4'(take_bits(4))));
                row_data[c*lane_w +: lane_w] = 8'(wgt[t][r][c]);
            end
            words.push_back({dest, op_weight, 2'(r), row_data});
        end
    endtask

    task automatic report(input string name, input int got, input int errs);
        $display("%-14s %0d results checked, %0d errors", name, got, errs);
        errors += errs;
        if (errs != 0) failed_tests++;
    endtask

    task automatic check_reset();
        int errs;
        errs = 0;
        repeat (8) begin
            if (ififo_rdy !== 1'b1) begin
                $display("Error reset_state: expected ififo_rdy 1, actual %b", ififo_rdy);
                errs++;
            end
            if (ofifo_rdy !== 1'b0) begin
                $display("Error reset_state: expected ofifo_rdy 0, actual %b", ofifo_rdy);
                errs++;
            end
            next_cycle();
        end
        report("reset_state", 0, errs);
    endtask

    task automatic run_test(input int idx);
        int          wi;
        int          got;
        int          errs;
        int          idle;
        bit          saw_full;
        logic [1:0]  dest;
        logic [31:0] x;
        logic [31:0] y;
        words.delete();
        exp_q.delete();
        wi       = 0;
        got      = 0;
        errs     = 0;
        idle     = 0;
        saw_full = 1'b0;
        dest     = node_tile0;
        if (modes[idx] == m_pass) dest = node_eject;
        if (modes[idx] == m_one) dest = node_tile1;
        if (modes[idx] == m_two || modes[idx] == m_bp) queue_weights(0, wsels[idx]);
        if (modes[idx] != m_pass) queue_weights(1, wsels[idx]);
        for (int v = 0; v < counts[idx]; v++) begin
            x = 32'(take_bits(32));
            words.push_back({dest, op_vector, 2'd0, x});
            case (modes[idx])
                m_pass:  y = x;
                m_one:   y = tile_model(1, x);
                default: y = tile_model(1, tile_model(0, x));
            endcase
            exp_q.push_back(y);
        end

        while (wi < words.size() || exp_q.size() > 0) begin
            if (!ififo_rdy) saw_full = 1'b1;
            if (wi == words.size()) idle++;
            ofifo_ren = 1'b0;
            // output held in back-pressure until the input side fills
            if (ofifo_rdy && (modes[idx] != m_bp || saw_full || idle > 40)) begin
                y = exp_q.pop_front();
                if (ofifo_rdata !== y) begin
                    $display("Error %s: expected %h, actual %h", names[idx], y, ofifo_rdata);
                    errs++;
                end
                got++;
                ofifo_ren = 1'b1;
            end
            ififo_wen = 1'b0;
            if (wi < words.size() && ififo_rdy) begin
                ififo_wdata = words[wi];
                ififo_wen   = 1'b1;
                wi++;
            end
            next_cycle();
        end

        ififo_wen = 1'b0;
        repeat (12) begin   // nothing may follow the last result
            ofifo_ren = 1'b0;
            if (ofifo_rdy) begin
                $display("%s: extra result %h after all expected results", names[idx],
                         ofifo_rdata);
                errs++;
                ofifo_ren = 1'b1;
            end
            next_cycle();
        end
        ofifo_ren = 1'b0;
        if (modes[idx] == m_bp && !saw_full) begin
            $display("%s: ififo_rdy never dropped while the output was held", names[idx]);
            errs++;
        end
        report(names[idx], got, errs);
    endtask

    initial begin
        arst_n       = 1'b1;
        ififo_wdata  = '0;
        ififo_wen    = 1'b0;
        ofifo_ren    = 1'b0;
        lfsr         = 32'hb466_3c6d;
        errors       = 0;
        failed_tests = 0;
        assert_fails = 0;
        #1 arst_n = 1'b0;   // clean falling edge for the async reset
        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;
        check_reset();
        for (int i = 0; i < n_table; i++) begin
            run_test(i);
        end
        assert_fails = i_noc_mlp_top.u_switch.u_switch_chk.fail_count;
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d", n_tests,
                 failed_tests, errors, assert_fails);
        if (failed_tests == 0 && assert_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: list.f
source/noc_mlp_pkg.sv
source/flit_if.sv
source/sync_fifo.sv
source/noc_switch.sv
source/mvm_tile.sv
source/noc_mlp_top.sv
tests/noc_mlp_assertions.sv
tests/noc_mlp_tb.sv

// File: Makefile
# Verilator flow for the NoC MLP testbench
VERILATOR  ?= verilator
TOP        ?= noc_mlp_tb
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= sim passed
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
